// ==== roce_pkg.sv ====
package roce_pkg;

  // stream beat geometry
  localparam int DATA_W = 128;
  localparam int KEEP_W = DATA_W / 8;

  localparam int NUM_QP = 8;
  localparam int QP_W   = $clog2(NUM_QP);

  localparam int MAC_W  = 48;

  // register strobe port
  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  // register map, byte addresses
  localparam logic [REG_ADDR_W-1:0] ADDR_MAC_LO    = 8'h00;
  localparam logic [REG_ADDR_W-1:0] ADDR_MAC_HI    = 8'h04;
  localparam logic [REG_ADDR_W-1:0] ADDR_DMAC_BASE = 8'h40;

  // one table entry is a low word and a high word
  localparam int DMAC_STRIDE = 8;

  // address range covered by the destination MAC table
  localparam logic [REG_ADDR_W-1:0] DMAC_SPAN = REG_ADDR_W'(NUM_QP * DMAC_STRIDE);

  typedef logic [MAC_W-1:0] mac_t;

  // qp is only meaningful on RoCE packets, zero on bypass traffic
  typedef struct packed {
    logic [DATA_W-1:0] tdata;
    logic [KEEP_W-1:0] tkeep;
    logic              tlast;
    logic [QP_W-1:0]   qp;
  } axis_beat_t;

endpackage: roce_pkg

// ==== roce_csr.sv ====
`timescale 1ns/10ps

module roce_csr (
  input  logic                                axis_aclk_i,
  input  logic                                rst_i,

  // register strobe port
  input  logic                                reg_wr_i,
  input  logic                                reg_rd_i,
  input  logic [roce_pkg::REG_ADDR_W-1:0]     reg_addr_i,
  input  logic [roce_pkg::REG_DATA_W-1:0]     reg_wdata_i,
  output logic [roce_pkg::REG_DATA_W-1:0]     reg_rdata_o,
  output logic                                reg_rvalid_o,

  // address lookup for the header stage
  input  logic [roce_pkg::QP_W-1:0]           lookup_qp_i,
  output roce_pkg::mac_t                      dmac_net_o,
  output roce_pkg::mac_t                      smac_net_o
);

  localparam int HI_W = roce_pkg::MAC_W - roce_pkg::REG_DATA_W;

  roce_pkg::mac_t mac_q;
  roce_pkg::mac_t dmac_q [roce_pkg::NUM_QP];

  logic [roce_pkg::REG_ADDR_W-1:0] tbl_off;
  logic                            tbl_hit;
  logic [roce_pkg::QP_W-1:0]       tbl_idx;
  logic                            tbl_hi;
  logic [roce_pkg::REG_DATA_W-1:0] rd_data;

  // byte lane 0 on the wire carries the most significant address byte
  function automatic roce_pkg::mac_t to_net(input roce_pkg::mac_t mac);
    roce_pkg::mac_t net;
    for (int b = 0; b < roce_pkg::MAC_W / 8; b++) begin
      net[8*b +: 8] = mac[8*(roce_pkg::MAC_W/8 - 1 - b) +: 8];
    end
    return net;
  endfunction

  // table decode, word aligned only
  assign tbl_off = reg_addr_i - roce_pkg::ADDR_DMAC_BASE;
  assign tbl_hit = (reg_addr_i >= roce_pkg::ADDR_DMAC_BASE) &&
                   (tbl_off < roce_pkg::DMAC_SPAN) &&
                   (reg_addr_i[1:0] == 2'b00);
  assign tbl_idx = tbl_off[$clog2(roce_pkg::DMAC_STRIDE) +: roce_pkg::QP_W];
  assign tbl_hi  = tbl_off[2];

  always_ff @(posedge axis_aclk_i) begin
    if (rst_i) begin
      mac_q <= '0;
      for (int i = 0; i < roce_pkg::NUM_QP; i++) begin
        dmac_q[i] <= '0;
      end
    end else if (reg_wr_i) begin
      if (reg_addr_i == roce_pkg::ADDR_MAC_LO) begin
        mac_q[roce_pkg::REG_DATA_W-1:0] <= reg_wdata_i;
      end else if (reg_addr_i == roce_pkg::ADDR_MAC_HI) begin
        mac_q[roce_pkg::MAC_W-1:roce_pkg::REG_DATA_W] <= reg_wdata_i[HI_W-1:0];
      end else if (tbl_hit) begin
        if (tbl_hi) begin
          dmac_q[tbl_idx][roce_pkg::MAC_W-1:roce_pkg::REG_DATA_W] <= reg_wdata_i[HI_W-1:0];
        end else begin
          dmac_q[tbl_idx][roce_pkg::REG_DATA_W-1:0] <= reg_wdata_i;
        end
      end
    end
  end

  // readback mux, unmapped reads as zero
  always_comb begin
    rd_data = '0;
    if (reg_addr_i == roce_pkg::ADDR_MAC_LO) begin
      rd_data = mac_q[roce_pkg::REG_DATA_W-1:0];
    end else if (reg_addr_i == roce_pkg::ADDR_MAC_HI) begin
      rd_data[HI_W-1:0] = mac_q[roce_pkg::MAC_W-1:roce_pkg::REG_DATA_W];
    end else if (tbl_hit) begin
      if (tbl_hi) begin
        rd_data[HI_W-1:0] = dmac_q[tbl_idx][roce_pkg::MAC_W-1:roce_pkg::REG_DATA_W];
      end else begin
        rd_data = dmac_q[tbl_idx][roce_pkg::REG_DATA_W-1:0];
      end
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (rst_i) begin
      reg_rvalid_o <= 1'b0;
      reg_rdata_o  <= '0;
    end else begin
      reg_rvalid_o <= reg_rd_i;
      if (reg_rd_i) begin
        reg_rdata_o <= rd_data;
      end
    end
  end

  assign dmac_net_o = to_net(dmac_q[lookup_qp_i]);
  assign smac_net_o = to_net(mac_q);

endmodule: roce_csr

// ==== mac_header_insert.sv ====
`timescale 1ns/10ps

module mac_header_insert (
  input  logic                      axis_aclk_i,
  input  logic                      rst_i,

  // RoCE stream in
  input  roce_pkg::axis_beat_t      s_beat_i,
  input  logic                      s_valid_i,
  output logic                      s_ready_o,

  // stamped stream out
  output roce_pkg::axis_beat_t      m_beat_o,
  output logic                      m_valid_o,
  input  logic                      m_ready_i,

  // address lookup
  output logic [roce_pkg::QP_W-1:0] lookup_qp_o,
  input  roce_pkg::mac_t            dmac_net_i,
  input  roce_pkg::mac_t            smac_net_i
);

  localparam int MAC_W = roce_pkg::MAC_W;

  logic                 first_q;
  logic                 out_valid_q;
  roce_pkg::axis_beat_t out_beat_q;
  roce_pkg::axis_beat_t stamped;
  logic                 accept;

  // stage takes a beat when empty or when its output drains this cycle
  assign s_ready_o = !out_valid_q || m_ready_i;
  assign accept    = s_valid_i && s_ready_o;

  assign lookup_qp_o = s_beat_i.qp;

  // bytes 0-5 dest, bytes 6-11 source, rest untouched
  always_comb begin
    stamped = s_beat_i;
    if (first_q) begin
      stamped.tdata[MAC_W-1:0]       = dmac_net_i;
      stamped.tdata[2*MAC_W-1:MAC_W] = smac_net_i;
    end
  end

  // next beat is a packet start after tlast
  always_ff @(posedge axis_aclk_i) begin
    if (rst_i) begin
      first_q <= 1'b1;
    end else if (accept) begin
      first_q <= s_beat_i.tlast;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (m_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (accept) begin
      out_beat_q <= stamped;
    end
  end

  assign m_beat_o  = out_beat_q;
  assign m_valid_o = out_valid_q;

endmodule: mac_header_insert

// ==== tx_stream_arbiter.sv ====
`timescale 1ns/10ps

module tx_stream_arbiter (
  input  logic                 axis_aclk_i,
  input  logic                 rst_i,

  // RoCE packets after header insertion
  input  roce_pkg::axis_beat_t roce_beat_i,
  input  logic                 roce_valid_i,
  output logic                 roce_ready_o,

  // non-RoCE bypass packets
  input  roce_pkg::axis_beat_t raw_beat_i,
  input  logic                 raw_valid_i,
  output logic                 raw_ready_o,

  // merged link toward the Ethernet MAC
  output roce_pkg::axis_beat_t m_beat_o,
  output logic                 m_valid_o,
  input  logic                 m_ready_i
);

  // source select: 0 is RoCE, 1 is bypass
  logic                 last_raw_q;
  logic                 lock_q;
  logic                 sel_raw;
  logic                 sel_valid;
  roce_pkg::axis_beat_t sel_beat;
  logic                 out_free;
  logic                 accept;
  logic                 out_valid_q;
  roce_pkg::axis_beat_t out_beat_q;

  assign out_free = !out_valid_q || m_ready_i;

  // inside a packet stay on the last source, otherwise round robin
  always_comb begin
    if (lock_q) begin
      sel_raw = last_raw_q;
    end else if (roce_valid_i && raw_valid_i) begin
      sel_raw = !last_raw_q;
    end else begin
      sel_raw = !roce_valid_i;
    end
  end

  assign sel_beat  = sel_raw ? raw_beat_i : roce_beat_i;
  assign sel_valid = sel_raw ? raw_valid_i : roce_valid_i;
  assign accept    = out_free && sel_valid;

  assign roce_ready_o = out_free && !sel_raw;
  assign raw_ready_o  = out_free && sel_raw;

  // pointer starts on bypass so RoCE wins first
  always_ff @(posedge axis_aclk_i) begin
    if (rst_i) begin
      last_raw_q <= 1'b1;
      lock_q     <= 1'b0;
    end else if (accept) begin
      last_raw_q <= sel_raw;
      lock_q     <= !sel_beat.tlast;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (m_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (accept) begin
      out_beat_q <= sel_beat;
    end
  end

  assign m_beat_o  = out_beat_q;
  assign m_valid_o = out_valid_q;

endmodule: tx_stream_arbiter

// ==== roce_tx_top.sv ====
`timescale 1ns/10ps

module roce_tx_top (
  input  logic                            axis_aclk_i,
  input  logic                            rst_i,

  // register strobe port
  input  logic                            reg_wr_i,
  input  logic                            reg_rd_i,
  input  logic [roce_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [roce_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [roce_pkg::REG_DATA_W-1:0] reg_rdata_o,
  output logic                            reg_rvalid_o,

  // RoCE transmit packets
  input  roce_pkg::axis_beat_t            roce_beat_i,
  input  logic                            roce_valid_i,
  output logic                            roce_ready_o,

  // non-RoCE packets bypassing the header stage
  input  roce_pkg::axis_beat_t            raw_beat_i,
  input  logic                            raw_valid_i,
  output logic                            raw_ready_o,

  // toward the Ethernet MAC
  output roce_pkg::axis_beat_t            tx_beat_o,
  output logic                            tx_valid_o,
  input  logic                            tx_ready_i
);

  logic [roce_pkg::QP_W-1:0] lookup_qp;
  roce_pkg::mac_t            dmac_net;
  roce_pkg::mac_t            smac_net;

  roce_pkg::axis_beat_t      hdr_beat;
  logic                      hdr_valid;
  logic                      hdr_ready;

  roce_csr u_csr (
    .axis_aclk_i  (axis_aclk_i),
    .rst_i        (rst_i),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_i     (reg_rd_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .lookup_qp_i  (lookup_qp),
    .dmac_net_o   (dmac_net),
    .smac_net_o   (smac_net)
  );

  mac_header_insert u_hdr (
    .axis_aclk_i (axis_aclk_i),
    .rst_i       (rst_i),
    .s_beat_i    (roce_beat_i),
    .s_valid_i   (roce_valid_i),
    .s_ready_o   (roce_ready_o),
    .m_beat_o    (hdr_beat),
    .m_valid_o   (hdr_valid),
    .m_ready_i   (hdr_ready),
    .lookup_qp_o (lookup_qp),
    .dmac_net_i  (dmac_net),
    .smac_net_i  (smac_net)
  );

  tx_stream_arbiter u_arb (
    .axis_aclk_i  (axis_aclk_i),
    .rst_i        (rst_i),
    .roce_beat_i  (hdr_beat),
    .roce_valid_i (hdr_valid),
    .roce_ready_o (hdr_ready),
    .raw_beat_i   (raw_beat_i),
    .raw_valid_i  (raw_valid_i),
    .raw_ready_o  (raw_ready_o),
    .m_beat_o     (tx_beat_o),
    .m_valid_o    (tx_valid_o),
    .m_ready_i    (tx_ready_i)
  );

endmodule: roce_tx_top

// ==== tb_roce_tx_vectors.svh ====
typedef struct packed {
  // bypass source when set
  logic                      raw;
  logic [roce_pkg::QP_W-1:0] qp;
  logic [7:0]                beats;
  logic [31:0]               seed;
  // random stall on tx ready
  logic                      stall;
} vec_t;

localparam int NUM_VEC = 15;

// rows sharing a name run together as one test
string vec_name [NUM_VEC] = '{
  "both_pending", "both_pending", "both_pending", "both_pending", "both_pending",
  "single_roce",
  "multi_roce", "multi_roce", "multi_roce",
  "bypass", "bypass",
  "back_pressure", "back_pressure", "back_pressure", "back_pressure"
};

// one row per packet
vec_t vec_row [NUM_VEC] = '{
  '{1'b0, 3'd2, 8'd3, 32'h2468_ace0, 1'b0},
  '{1'b1, 3'd0, 8'd2, 32'h1357_9bdf, 1'b0},
  '{1'b0, 3'd5, 8'd1, 32'h9876_5432, 1'b0},
  '{1'b1, 3'd0, 8'd3, 32'h0f1e_2d3c, 1'b0},
  '{1'b0, 3'd7, 8'd2, 32'h4b5a_6978, 1'b0},
  '{1'b0, 3'd3, 8'd1, 32'h1a2b_3c4d, 1'b0},
  '{1'b0, 3'd1, 8'd3, 32'h0badf00d, 1'b0},
  '{1'b0, 3'd6, 8'd2, 32'h7e57_0c0d, 1'b0},
  '{1'b0, 3'd0, 8'd4, 32'hc0ff_ee11, 1'b0},
  '{1'b1, 3'd0, 8'd2, 32'h5a5a_0102, 1'b0},
  '{1'b1, 3'd0, 8'd1, 32'h3c3c_0203, 1'b0},
  '{1'b0, 3'd4, 8'd3, 32'h8899_aabb, 1'b1},
  '{1'b1, 3'd0, 8'd4, 32'hccdd_eeff, 1'b1},
  '{1'b0, 3'd1, 8'd2, 32'h1122_3344, 1'b1},
  '{1'b1, 3'd0, 8'd1, 32'h5566_7788, 1'b1}
};

// ==== tb_roce_tx.sv ====
`timescale 1ns/10ps

module tb_roce_tx;

  bit                              clk;
  logic                            rst;
  logic                            reg_wr;
  logic                            reg_rd;
  logic [roce_pkg::REG_ADDR_W-1:0] reg_addr;
  logic [roce_pkg::REG_DATA_W-1:0] reg_wdata;
  logic [roce_pkg::REG_DATA_W-1:0] reg_rdata;
  logic                            reg_rvalid;
  roce_pkg::axis_beat_t            roce_beat;
  logic                            roce_valid;
  logic                            roce_ready;
  roce_pkg::axis_beat_t            raw_beat;
  logic                            raw_valid;
  logic                            raw_ready;
  roce_pkg::axis_beat_t            tx_beat;
  logic                            tx_valid;
  logic                            tx_ready;

  roce_pkg::mac_t       local_mac;
  roce_pkg::mac_t       dmac_tbl [roce_pkg::NUM_QP];
  roce_pkg::axis_beat_t exp_q [$];
  // arbiter pointer model starts on bypass so RoCE wins first
  bit                   last_raw = 1'b1;
  bit                   stall_en;
  logic [31:0]          rnd;

  `include "tb_roce_tx_vectors.svh"

  roce_tx_top dut_i (
    .axis_aclk_i  (clk),
    .rst_i        (rst),
    .reg_wr_i     (reg_wr),
    .reg_rd_i     (reg_rd),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .reg_rvalid_o (reg_rvalid),
    .roce_beat_i  (roce_beat),
    .roce_valid_i (roce_valid),
    .roce_ready_o (roce_ready),
    .raw_beat_i   (raw_beat),
    .raw_valid_i  (raw_valid),
    .raw_ready_o  (raw_ready),
    .tx_beat_o    (tx_beat),
    .tx_valid_o   (tx_valid),
    .tx_ready_i   (tx_ready)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // random ready only while a back-pressure test runs
  initial begin
    tx_ready = 1'b1;
    forever begin
      @(negedge clk);
      rnd = $urandom;
      tx_ready = stall_en ? rnd[0] : 1'b1;
    end
  end

  function automatic int total_beats();
    int sum;
    sum = 0;
    for (int r = 0; r < NUM_VEC; r++)
      sum += int'(vec_row[r].beats);
    return sum;
  endfunction

  initial begin
    int limit;
    int cycles;
    limit = 4 * total_beats() + 200;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= limit) begin
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $fatal(1, "run stopped by the cycle limit");
      end
    end
  end

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_wr    = 1'b1;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  // read data is due one cycle after the strobe
  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] expected);
    reg_addr = addr;
    reg_rd   = 1'b1;
    @(negedge clk);
    reg_rd = 1'b0;
    check_value({name, " rvalid"}, 256'(1), 256'(reg_rvalid));
    check_value(name, 256'(expected), 256'(reg_rdata));
  endtask

  task automatic setup_registers();
    logic [7:0] addr;
    write_reg(roce_pkg::ADDR_MAC_LO, local_mac[31:0]);
    write_reg(roce_pkg::ADDR_MAC_HI, {16'h0, local_mac[47:32]});
    write_reg(8'h08, 32'hdead_beef);
    for (int i = 0; i < roce_pkg::NUM_QP; i++) begin
      addr = roce_pkg::ADDR_DMAC_BASE + 8'(roce_pkg::DMAC_STRIDE * i);
      write_reg(addr, dmac_tbl[i][31:0]);
      write_reg(addr + 8'd4, {16'h0, dmac_tbl[i][47:32]});
    end
    read_check("mac_lo", roce_pkg::ADDR_MAC_LO, local_mac[31:0]);
    read_check("mac_hi", roce_pkg::ADDR_MAC_HI, {16'h0, local_mac[47:32]});
    for (int i = 0; i < roce_pkg::NUM_QP; i++) begin
      addr = roce_pkg::ADDR_DMAC_BASE + 8'(roce_pkg::DMAC_STRIDE * i);
      read_check($sformatf("dmac%0d_lo", i), addr, dmac_tbl[i][31:0]);
      read_check($sformatf("dmac%0d_hi", i), addr + 8'd4, {16'h0, dmac_tbl[i][47:32]});
    end
    read_check("unmapped 0x08", 8'h08, '0);
    read_check("unmapped 0x80", 8'h80, '0);
    @(negedge clk);
    check_value("rvalid after reads", 256'(0), 256'(reg_rvalid));
  endtask

  function automatic roce_pkg::axis_beat_t make_beat(input int r, input int b);
    roce_pkg::axis_beat_t beat;
    logic [31:0]          seed;
    seed = vec_row[r].seed;
    for (int w = 0; w < roce_pkg::DATA_W / 32; w++)
      beat.tdata[32*w +: 32] = seed + 32'h9e37_79b9 * 32'(4 * b + w + 1);
    beat.tlast = (b == int'(vec_row[r].beats) - 1);
    // partial keep on the closing beat
    beat.tkeep = beat.tlast ? ({roce_pkg::KEEP_W{1'b1}} >> seed[3:0])
                            : {roce_pkg::KEEP_W{1'b1}};
    beat.qp = vec_row[r].raw ? '0 : vec_row[r].qp;
    return beat;
  endfunction

  // byte lane 0 gets address bits 47:40
  function automatic roce_pkg::axis_beat_t expect_beat(input int r, input int b);
    roce_pkg::axis_beat_t beat;
    beat = make_beat(r, b);
    if (!vec_row[r].raw && b == 0) begin
      for (int k = 0; k < 6; k++) begin
        beat.tdata[8*k +: 8]       = dmac_tbl[vec_row[r].qp][8*(5-k) +: 8];
        beat.tdata[8*(k+6) +: 8]   = local_mac[8*(5-k) +: 8];
      end
    end
    return beat;
  endfunction

  // packet level round robin with both sources pending while they have rows
  task automatic build_expected(input int first, input int last);
    int roce_rows [$];
    int raw_rows [$];
    int r;
    bit pick_raw;
    for (int i = first; i <= last; i++) begin
      if (vec_row[i].raw)
        raw_rows.push_back(i);
      else
        roce_rows.push_back(i);
    end
    while (roce_rows.size() > 0 || raw_rows.size() > 0) begin
      if (roce_rows.size() > 0 && raw_rows.size() > 0)
        pick_raw = !last_raw;
      else
        pick_raw = (raw_rows.size() > 0);
      if (pick_raw)
        r = raw_rows.pop_front();
      else
        r = roce_rows.pop_front();
      for (int b = 0; b < int'(vec_row[r].beats); b++)
        exp_q.push_back(expect_beat(r, b));
      last_raw = pick_raw;
    end
  endtask

  task automatic send_beat(input bit raw, input roce_pkg::axis_beat_t beat);
    logic taken;
    taken = 1'b0;
    if (raw) begin
      raw_beat  = beat;
      raw_valid = 1'b1;
    end else begin
      roce_beat  = beat;
      roce_valid = 1'b1;
    end
    while (!taken) begin
      #1;
      taken = raw ? raw_ready : roce_ready;
      @(negedge clk);
    end
  endtask

  task automatic drive_source(input bit raw, input int first, input int last);
    for (int r = first; r <= last; r++) begin
      if (vec_row[r].raw == raw) begin
        for (int b = 0; b < int'(vec_row[r].beats); b++)
          send_beat(raw, make_beat(r, b));
      end
    end
    if (raw)
      raw_valid = 1'b0;
    else
      roce_valid = 1'b0;
  endtask

  task automatic collect(input string name, input int count);
    int got;
    got = 0;
    while (got < count) begin
      @(negedge clk);
      #1;
      if (tx_valid && tx_ready) begin
        check_value($sformatf("%s beat %0d", name, got), 256'(exp_q.pop_front()),
                    256'(tx_beat));
        got++;
      end
    end
  endtask

  task automatic run_group(input int first, input int last);
    int count;
    build_expected(first, last);
    count = exp_q.size();
    stall_en = vec_row[first].stall;
    // bypass starts a cycle late so both meet at the arbiter together
    fork
      drive_source(1'b0, first, last);
      begin
        @(negedge clk);
        drive_source(1'b1, first, last);
      end
      collect(vec_name[first], count);
    join
    stall_en = 1'b0;
    repeat (3) begin
      @(negedge clk);
      #1;
      check_value({vec_name[first], " idle"}, 256'(0), 256'(tx_valid));
    end
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] hi;
    logic [31:0] lo;
    int          first;
    int          last;
    void'($urandom(79605));
    hi = $urandom;
    lo = $urandom;
    local_mac = {hi[15:0], lo};
    for (int i = 0; i < roce_pkg::NUM_QP; i++) begin
      hi = $urandom;
      lo = $urandom;
      dmac_tbl[i] = {hi[15:0], lo};
    end
    rst        = 1'b1;
    reg_wr     = 1'b0;
    reg_rd     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    roce_beat  = '0;
    roce_valid = 1'b0;
    raw_beat   = '0;
    raw_valid  = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("reset tx_valid", 256'(0), 256'(tx_valid));
    check_value("reset reg_rvalid", 256'(0), 256'(reg_rvalid));
    setup_registers();
    first = 0;
    while (first < NUM_VEC) begin
      last = first;
      while (last + 1 < NUM_VEC && vec_name[last + 1] == vec_name[first])
        last++;
      run_group(first, last);
      first = last + 1;
    end
    $display("TEST OK");
    $finish;
  end

endmodule: tb_roce_tx

// ==== build.f ====
+incdir+.
roce_pkg.sv
roce_csr.sv
mac_header_insert.sv
tx_stream_arbiter.sv
roce_tx_top.sv
tb_roce_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_roce_tx -f build.f

out=$(./obj_dir/Vtb_roce_tx || true)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
